//--- compile.f
+incdir+rtl
rtl/dbg_monitor_pkg.sv
rtl/instr_classifier.sv
rtl/debug_cause_tracker.sv
rtl/entry_capture.sv
rtl/wb_status_regs.sv
rtl/dbg_monitor_top.sv
testbench/tb_dbg_monitor.sv

//--- Makefile
SRCS := $(shell grep '\.sv$$' compile.f) rtl/dbg_monitor_settings.svh

.PHONY: all run clean

all: run

obj_dir/Vtb_dbg_monitor: compile.f $(SRCS)
	verilator --binary --timing --top-module tb_dbg_monitor -f compile.f

run: obj_dir/Vtb_dbg_monitor
	@out="$$(./obj_dir/Vtb_dbg_monitor 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- testbench/tb_dbg_monitor.sv
/* Testbench for the debug monitor: clock, reset, LFSR, reference cause model,
   stimulus, compare tasks, read compare process and result messages */

`timescale 1ns/100ps
`include "dbg_monitor_settings.svh"

module tb_dbg_monitor;

  localparam int ACK_TIMEOUT = 16;

  logic                             cov_assert_if;
  logic                             reset_i;
  dbg_monitor_pkg::core_obs_t       obs;
  dbg_monitor_pkg::wb_req_t         wb_req;
  dbg_monitor_pkg::wb_rsp_t         wb_rsp;
  dbg_monitor_pkg::monitor_status_t exp_status;
  logic [15:0]                      lfsr_state;

  // Expected read results, in issue order
  string                exp_name_q[$];
  logic [`DBG_XLEN-1:0] exp_word_q[$];
  logic                 exp_is_status_q[$];

  dbg_monitor_top DUT (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .obs_i         (obs),
    .wb_req_i      (wb_req),
    .wb_rsp_o      (wb_rsp)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #20 cov_assert_if = ~cov_assert_if;
  end

  // --------------------------------------------------
  // Random numbers and reference model
  // --------------------------------------------------
  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic rand_bit();
    lfsr_state = {lfsr_state[14:0],
                  lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
    return lfsr_state[0];
  endfunction

  function automatic logic [`DBG_XLEN-1:0] rand_word();
    logic [`DBG_XLEN-1:0] w;
    int                   k;
    w = '0;
    for (k = 0; k < `DBG_XLEN; k++) begin
      w = {w[`DBG_XLEN-2:0], rand_bit()};
    end
    return w;
  endfunction

  // Lowest priority first, later hits override
  function automatic dbg_monitor_pkg::dbg_cause_e ref_cause(input logic trig,
      input logic ebreak_hit, input logic halt_req, input logic step);
    dbg_monitor_pkg::dbg_cause_e c;
    c = dbg_monitor_pkg::NONE;
    if (step) begin
      c = dbg_monitor_pkg::STEP;
    end
    if (halt_req) begin
      c = dbg_monitor_pkg::HALTREQ;
    end
    if (ebreak_hit) begin
      c = dbg_monitor_pkg::EBREAK;
    end
    if (trig) begin
      c = dbg_monitor_pkg::TRIGGER;
    end
    return c;
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [`DBG_XLEN-1:0] exp_val,
                            input logic [`DBG_XLEN-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  task automatic check_status(input string name,
                              input dbg_monitor_pkg::monitor_status_t exp_val,
                              input dbg_monitor_pkg::monitor_status_t act_val);
    if (act_val !== exp_val) begin
      $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
      abort_run();
    end
  endtask

  // Compares each acknowledged read with the oldest expectation
  always @(negedge cov_assert_if) begin
    if (!reset_i && wb_rsp.ack && !wb_req.we) begin
      if (exp_word_q.size() == 0) begin
        $display("A read was acknowledged with no expected value queued");
        abort_run();
      end else begin
        if (exp_is_status_q[0]) begin
          check_status(exp_name_q[0], dbg_monitor_pkg::monitor_status_t'(exp_word_q[0]),
                       dbg_monitor_pkg::monitor_status_t'(wb_rsp.dat_r));
        end else begin
          check_word(exp_name_q[0], exp_word_q[0], wb_rsp.dat_r);
        end
        void'(exp_name_q.pop_front());
        void'(exp_word_q.pop_front());
        void'(exp_is_status_q.pop_front());
      end
    end
  end

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  // One cycle of v, then back to idle
  task automatic pulse_obs(input dbg_monitor_pkg::core_obs_t v);
    @(posedge cov_assert_if);
    obs <= v;
    @(posedge cov_assert_if);
    obs <= '0;
  endtask

  task automatic wb_transfer(input logic we, input logic [`DBG_WB_ADDR_W-1:0] adr,
                             input logic [`DBG_XLEN-1:0] data);
    int cycles;
    cycles = 0;
    @(posedge cov_assert_if);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: data};
    @(negedge cov_assert_if);
    while (!wb_rsp.ack && cycles < ACK_TIMEOUT) begin
      @(negedge cov_assert_if);
      cycles++;
    end
    if (!wb_rsp.ack) begin
      $display("No Wishbone ack within %0d cycles at index %0d", ACK_TIMEOUT, adr);
      abort_run();
    end else if (cycles != 1) begin
      $display("Wishbone ack came %0d cycles after stb instead of 1", cycles);
      abort_run();
    end
    @(posedge cov_assert_if);
    wb_req <= '0;
  endtask

  task automatic read_expect(input string name, input logic [`DBG_WB_ADDR_W-1:0] adr,
                             input logic [`DBG_XLEN-1:0] exp_val, input logic is_status);
    exp_name_q.push_back(name);
    exp_word_q.push_back(exp_val);
    exp_is_status_q.push_back(is_status);
    wb_transfer(1'b0, adr, '0);
  endtask

  task automatic read_status(input string name);
    read_expect(name, `DBG_REG_STATUS, exp_status, 1'b1);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    dbg_monitor_pkg::core_obs_t v;
    logic                       trig, ebr, ebm, dreq, step;
    logic [`DBG_XLEN-1:0]       pc_ebreak, last_rvfi, pc_debug, addr;
    int                         idx;
    lfsr_state = 16'd90;
    reset_i    = 1'b1;
    obs        = '0;
    wb_req     = '0;
    exp_status = '0;
    repeat (10) @(posedge cov_assert_if);
    reset_i <= 1'b0;

    // All words zero after reset, unmapped ones too
    for (idx = 0; idx < 8; idx++) begin
      read_expect($sformatf("reset word %0d", idx), idx[`DBG_WB_ADDR_W-1:0], '0, idx == 0);
    end

    // Cause priority in FUNCTIONAL
    pc_ebreak = '0;
    for (idx = 0; idx < 16; idx++) begin
      trig = rand_bit();
      ebr  = rand_bit() || (idx == 0);
      ebm  = rand_bit();
      dreq = rand_bit();
      step = rand_bit();
      v = '0;
      v.ctrl          = dbg_monitor_pkg::FUNCTIONAL;
      v.trigger_match = trig;
      v.dcsr_ebreakm  = ebm;
      v.debug_req     = dreq;
      v.dcsr_step     = step;
      v.wb_valid      = 1'b1;
      v.wb_pc         = rand_word();
      v.wb_instr = ebr ? (rand_bit() ? `DBG_INSTR_CEBREAK : `DBG_INSTR_EBREAK) : 32'h0000_0013;
      if (ebr) begin
        pc_ebreak = v.wb_pc;
      end
      pulse_obs(v);
      exp_status.cause = ref_cause(trig, ebr && ebm, dreq, step);
      read_status("cause in FUNCTIONAL");
      read_expect("ebreak PC", `DBG_REG_PC_EBREAK, pc_ebreak, 1'b0);
    end

    // Debug entry with and without a valid RVFI PC
    for (idx = 0; idx < 4; idx++) begin
      v = '0;
      v.rvfi_valid = 1'b1;
      v.rvfi_pc    = rand_word();
      last_rvfi    = v.rvfi_pc;
      pulse_obs(v);
      v = '0;
      v.ctrl         = dbg_monitor_pkg::DEBUG_TAKEN;
      v.debug_mode   = 1'b1;
      v.debug_req    = (idx == 1);
      v.rvfi_valid   = rand_bit();
      v.rvfi_pc      = rand_word();
      v.dm_halt_addr = rand_word();
      pc_debug = v.rvfi_valid ? v.rvfi_pc : last_rvfi;
      addr     = v.dm_halt_addr & ~32'h3;
      if (v.debug_req) begin
        exp_status.cause = ref_cause(1'b0, 1'b0, 1'b1, 1'b0);
      end
      // Two DEBUG_TAKEN cycles, only the first one loads the halt address
      @(posedge cov_assert_if);
      obs <= v;
      v.dm_halt_addr = ~v.dm_halt_addr;
      pulse_obs(v);
      read_expect("PC at debug entry", `DBG_REG_PC_DEBUG, pc_debug, 1'b0);
      read_expect("halt address", `DBG_REG_HALT, addr, 1'b0);
      read_status("cause in DEBUG_TAKEN");
    end

    v = '0;
    v.ctrl      = dbg_monitor_pkg::BOOT_SET;
    v.boot_addr = rand_word();
    pulse_obs(v);
    read_expect("boot address", `DBG_REG_BOOT, v.boot_addr & ~32'h3, 1'b0);

    // Exception address only in debug mode
    v = '0;
    v.debug_mode        = 1'b1;
    v.illegal_insn      = 1'b1;
    v.pc_set            = 1'b1;
    v.dm_exception_addr = rand_word();
    addr = v.dm_exception_addr & ~32'h3;
    pulse_obs(v);
    read_expect("exception address", `DBG_REG_EXC, addr, 1'b0);
    v.debug_mode        = 1'b0;
    v.dm_exception_addr = rand_word();
    pulse_obs(v);
    read_expect("exception address outside debug", `DBG_REG_EXC, addr, 1'b0);

    // WFI sleep and wake
    v = '0;
    v.ctrl     = dbg_monitor_pkg::FUNCTIONAL;
    v.wb_valid = 1'b1;
    v.wb_instr = `DBG_INSTR_WFI;
    pulse_obs(v);
    exp_status.cause  = ref_cause(1'b0, 1'b0, 1'b0, 1'b0);
    exp_status.in_wfi = 1'b1;
    read_status("WFI entry");
    v = '0;
    v.pending_irq = 1'b1;
    pulse_obs(v);
    exp_status.in_wfi = 1'b0;
    read_status("wake on pending irq");
    v = '0;
    v.ctrl      = dbg_monitor_pkg::FUNCTIONAL;
    v.wb_valid  = 1'b1;
    v.wb_instr  = `DBG_INSTR_WFI;
    v.debug_req = 1'b1;
    pulse_obs(v);
    exp_status.cause = ref_cause(1'b0, 1'b0, 1'b1, 1'b0);
    read_status("WFI with debug request");

    // Sticky flags for M-mode dret and debug CSR access
    v = '0;
    v.wb_valid = 1'b1;
    v.wb_instr = `DBG_INSTR_DRET;
    pulse_obs(v);
    exp_status.sticky_mret_dret = 1'b1;
    read_status("dret outside debug");
    v = '0;
    v.id_valid           = 1'b1;
    v.id_decoding        = 1'b1;
    v.id_instr.i.opcode  = `DBG_OPCODE_SYSTEM;
    v.id_instr.i.funct3  = 3'b010;
    v.id_instr.i.rd      = 5'd1;
    v.id_instr.i.csr     = `DBG_CSR_DCSR_LO | {10'd0, rand_bit(), rand_bit()};
    pulse_obs(v);
    exp_status.sticky_mmode_dcsr = 1'b1;
    read_status("debug CSR access outside debug");
    wb_transfer(1'b1, `DBG_REG_STATUS, '0);
    exp_status.sticky_mret_dret  = 1'b0;
    exp_status.sticky_mmode_dcsr = 1'b0;
    read_status("sticky clear");
    // Same accesses inside debug mode leave the flags low
    v.debug_mode = 1'b1;
    v.wb_valid   = 1'b1;
    v.wb_instr   = `DBG_INSTR_DRET;
    pulse_obs(v);
    read_status("accesses in debug mode");

    // First decode in debug mode is flagged once, the read overlaps the pulse
    v = '0;
    v.debug_mode  = 1'b1;
    v.id_valid    = 1'b1;
    v.id_decoding = 1'b1;
    @(posedge cov_assert_if);
    obs <= v;
    exp_status.first_debug_ins = 1'b1;
    read_status("first instruction in debug mode");
    exp_status.first_debug_ins = 1'b0;
    read_status("later instruction in debug mode");
    @(posedge cov_assert_if);
    obs <= '0;

    if (exp_word_q.size() != 0) begin
      $display("%0d expected reads were never acknowledged", exp_word_q.size());
      abort_run();
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

//--- rtl/dbg_monitor_top.sv
/* Top level of the debug monitor: classifier, cause tracker,
   entry capture and Wishbone status port */

`timescale 1ns/100ps
`include "dbg_monitor_settings.svh"

module dbg_monitor_top (
  input  logic                    cov_assert_if,
  input  logic                    reset_i,
  input  dbg_monitor_pkg::core_obs_t obs_i,
  input  dbg_monitor_pkg::wb_req_t   wb_req_i,
  output dbg_monitor_pkg::wb_rsp_t   wb_rsp_o
);

  dbg_monitor_pkg::instr_events_t   events;
  dbg_monitor_pkg::dbg_cause_e      cause;
  dbg_monitor_pkg::monitor_status_t status;
  logic                             in_wfi;
  logic                             first_debug_ins;
  logic                             sticky_dret;
  logic                             sticky_dcsr;
  logic                             clear_sticky;
  logic [`DBG_XLEN-1:0]             pc_at_debug;
  logic [`DBG_XLEN-1:0]             pc_at_ebreak;
  logic [`DBG_XLEN-1:0]             halt_addr;
  logic [`DBG_XLEN-1:0]             exc_addr;
  logic [`DBG_XLEN-1:0]             boot_addr;

  instr_classifier u_classifier (
    .obs_i    (obs_i),
    .events_o (events)
  );

  debug_cause_tracker u_cause_tracker (
    .cov_assert_if (cov_assert_if),
    .reset_i       (reset_i),
    .obs_i         (obs_i),
    .events_i      (events),
    .cause_o       (cause),
    .in_wfi_o      (in_wfi)
  );

  entry_capture u_entry_capture (
    .cov_assert_if     (cov_assert_if),
    .reset_i           (reset_i),
    .obs_i             (obs_i),
    .events_i          (events),
    .clear_sticky_i    (clear_sticky),
    .pc_at_debug_o     (pc_at_debug),
    .pc_at_ebreak_o    (pc_at_ebreak),
    .halt_addr_o       (halt_addr),
    .exc_addr_o        (exc_addr),
    .boot_addr_o       (boot_addr),
    .first_debug_ins_o (first_debug_ins),
    .sticky_dret_o     (sticky_dret),
    .sticky_dcsr_o     (sticky_dcsr)
  );

  // Status word as seen at register index 0
  always_comb begin
    status                   = '0;
    status.cause             = cause;
    status.in_wfi            = in_wfi;
    status.first_debug_ins   = first_debug_ins;
    status.sticky_mret_dret  = sticky_dret;
    status.sticky_mmode_dcsr = sticky_dcsr;
  end

  wb_status_regs u_wb_regs (
    .cov_assert_if  (cov_assert_if),
    .reset_i        (reset_i),
    .wb_req_i       (wb_req_i),
    .wb_rsp_o       (wb_rsp_o),
    .status_i       (status),
    .pc_at_debug_i  (pc_at_debug),
    .pc_at_ebreak_i (pc_at_ebreak),
    .halt_addr_i    (halt_addr),
    .exc_addr_i     (exc_addr),
    .boot_addr_i    (boot_addr),
    .clear_sticky_o (clear_sticky)
  );

endmodule

//--- rtl/wb_status_regs.sv
/* Wishbone classic slave that serves the captured monitor state
   and clears the sticky flags on a status write */

`timescale 1ns/100ps
`include "dbg_monitor_settings.svh"

module wb_status_regs (
  input  logic                            cov_assert_if,
  input  logic                            reset_i,
  input  dbg_monitor_pkg::wb_req_t         wb_req_i,
  output dbg_monitor_pkg::wb_rsp_t         wb_rsp_o,
  input  dbg_monitor_pkg::monitor_status_t status_i,
  input  logic [`DBG_XLEN-1:0]            pc_at_debug_i,
  input  logic [`DBG_XLEN-1:0]            pc_at_ebreak_i,
  input  logic [`DBG_XLEN-1:0]            halt_addr_i,
  input  logic [`DBG_XLEN-1:0]            exc_addr_i,
  input  logic [`DBG_XLEN-1:0]            boot_addr_i,
  output logic                            clear_sticky_o
);

  logic                 ack_q;
  logic                 clear_q;
  logic                 xfer_start;
  logic [`DBG_XLEN-1:0] rd_word;
  logic [`DBG_XLEN-1:0] rd_data_q;

  // New transfer when selected and not already in its ack cycle
  assign xfer_start = wb_req_i.cyc && wb_req_i.stb && !ack_q;

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------
  always_comb begin
    case (wb_req_i.adr)
      `DBG_REG_STATUS:    rd_word = status_i;
      `DBG_REG_PC_DEBUG:  rd_word = pc_at_debug_i;
      `DBG_REG_PC_EBREAK: rd_word = pc_at_ebreak_i;
      `DBG_REG_HALT:      rd_word = halt_addr_i;
      `DBG_REG_EXC:       rd_word = exc_addr_i;
      `DBG_REG_BOOT:      rd_word = boot_addr_i;
      default:            rd_word = '0;
    endcase
  end

  // --------------------------------------------------
  // Ack and clear strobe
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      ack_q   <= xfer_start;
      clear_q <= xfer_start && wb_req_i.we && (wb_req_i.adr == `DBG_REG_STATUS);
    end
  end

  // Read data lines up with ack
  always_ff @(posedge cov_assert_if) begin
    if (xfer_start) begin
      rd_data_q <= rd_word;
    end
  end

  // Ack is dropped at once if the master lets go of stb
  assign wb_rsp_o.ack   = ack_q && wb_req_i.cyc && wb_req_i.stb;
  assign wb_rsp_o.dat_r = rd_data_q;
  assign clear_sticky_o = clear_q;

endmodule

//--- rtl/entry_capture.sv
/* Captured addresses at debug entry, first-debug-instruction pulse
   and sticky flags for debug accesses made in M-mode */

`timescale 1ns/100ps
`include "dbg_monitor_settings.svh"

module entry_capture (
  input  logic                          cov_assert_if,
  input  logic                          reset_i,
  input  dbg_monitor_pkg::core_obs_t     obs_i,
  input  dbg_monitor_pkg::instr_events_t events_i,
  input  logic                          clear_sticky_i,
  output logic [`DBG_XLEN-1:0]          pc_at_debug_o,
  output logic [`DBG_XLEN-1:0]          pc_at_ebreak_o,
  output logic [`DBG_XLEN-1:0]          halt_addr_o,
  output logic [`DBG_XLEN-1:0]          exc_addr_o,
  output logic [`DBG_XLEN-1:0]          boot_addr_o,
  output logic                          first_debug_ins_o,
  output logic                          sticky_dret_o,
  output logic                          sticky_dcsr_o
);

  logic [`DBG_XLEN-1:0] rvfi_pc_q;
  logic                 halt_taken_q;
  logic                 first_seen_q;
  logic                 any_ebreak;
  logic                 exc_in_debug;

  assign any_ebreak   = events_i.is_ebreak || events_i.is_cebreak;
  assign exc_in_debug = (obs_i.illegal_insn || obs_i.ecall_insn) && obs_i.pc_set &&
                        obs_i.debug_mode;

  // --------------------------------------------------
  // Program counters
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      rvfi_pc_q      <= '0;
      pc_at_debug_o  <= '0;
      pc_at_ebreak_o <= '0;
    end else begin
      // RVFI PC is only stable while valid, keep the last one
      if (obs_i.rvfi_valid) begin
        rvfi_pc_q <= obs_i.rvfi_pc;
      end
      if (obs_i.ctrl == dbg_monitor_pkg::DEBUG_TAKEN) begin
        pc_at_debug_o <= obs_i.rvfi_valid ? obs_i.rvfi_pc : rvfi_pc_q;
      end
      if (any_ebreak) begin
        pc_at_ebreak_o <= obs_i.wb_pc;
      end
    end
  end

  // --------------------------------------------------
  // Halt, exception and boot addresses
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      halt_taken_q <= 1'b0;
      halt_addr_o  <= '0;
      exc_addr_o   <= '0;
      boot_addr_o  <= '0;
    end else begin
      // First DEBUG_TAKEN cycle of an entry only
      if (!halt_taken_q && (obs_i.ctrl == dbg_monitor_pkg::DEBUG_TAKEN)) begin
        halt_addr_o  <= {obs_i.dm_halt_addr[`DBG_XLEN-1:2], 2'b00};
        halt_taken_q <= 1'b1;
      end
      // Rearm once out of debug, or on ebreak re-entry from inside
      if ((!obs_i.debug_mode && halt_taken_q) || (obs_i.debug_mode && any_ebreak)) begin
        halt_taken_q <= 1'b0;
      end
      if (exc_in_debug) begin
        exc_addr_o <= {obs_i.dm_exception_addr[`DBG_XLEN-1:2], 2'b00};
      end
      if (obs_i.ctrl == dbg_monitor_pkg::BOOT_SET) begin
        boot_addr_o <= {obs_i.boot_addr[`DBG_XLEN-1:2], 2'b00};
      end
    end
  end

  // --------------------------------------------------
  // First decoded instruction in debug mode
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      first_seen_q      <= 1'b0;
      first_debug_ins_o <= 1'b0;
    end else begin
      first_debug_ins_o <= 1'b0;
      if (!obs_i.debug_mode) begin
        first_seen_q <= 1'b0;
      end else if (!first_seen_q && obs_i.id_decoding && obs_i.id_valid) begin
        first_seen_q      <= 1'b1;
        first_debug_ins_o <= 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Sticky M-mode flags
  // --------------------------------------------------
  // A new event in the clear cycle is kept
  always_ff @(posedge cov_assert_if) begin
    if (reset_i || clear_sticky_i) begin
      sticky_dret_o <= 1'b0;
      sticky_dcsr_o <= 1'b0;
    end
    if (!reset_i) begin
      if (events_i.is_dret && !obs_i.debug_mode) begin
        sticky_dret_o <= 1'b1;
      end
      if (events_i.dbg_csr_access && !obs_i.debug_mode) begin
        sticky_dcsr_o <= 1'b1;
      end
    end
  end

endmodule

//--- rtl/debug_cause_tracker.sv
/* Priority tracking of the debug cause the core should take next,
   plus the WFI sleep state */

`timescale 1ns/100ps

module debug_cause_tracker (
  input  logic                          cov_assert_if,
  input  logic                          reset_i,
  input  dbg_monitor_pkg::core_obs_t     obs_i,
  input  dbg_monitor_pkg::instr_events_t events_i,
  output dbg_monitor_pkg::dbg_cause_e    cause_o,
  output logic                          in_wfi_o
);

  dbg_monitor_pkg::dbg_cause_e cause_q;
  logic                        in_wfi_q;
  logic                        ebreak_to_debug;
  logic                        in_functional;
  logic                        in_debug_taken;
  logic                        wfi_enter;
  logic                        wfi_wake;

  // ebreak only enters debug when dcsr.ebreakm is set
  assign ebreak_to_debug = obs_i.dcsr_ebreakm && (events_i.is_ebreak || events_i.is_cebreak);

  assign in_functional  = (obs_i.ctrl == dbg_monitor_pkg::FUNCTIONAL) && !obs_i.debug_mode;
  assign in_debug_taken = (obs_i.ctrl == dbg_monitor_pkg::DEBUG_TAKEN);

  // --------------------------------------------------
  // Expected cause
  // --------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      cause_q <= dbg_monitor_pkg::NONE;
    end else if (in_functional) begin
      if (obs_i.trigger_match) begin
        cause_q <= dbg_monitor_pkg::TRIGGER;
      end else if (ebreak_to_debug) begin
        cause_q <= dbg_monitor_pkg::EBREAK;
      end else if (obs_i.debug_req) begin
        cause_q <= dbg_monitor_pkg::HALTREQ;
      end else if (obs_i.dcsr_step) begin
        cause_q <= dbg_monitor_pkg::STEP;
      end else begin
        cause_q <= dbg_monitor_pkg::NONE;
      end
    end else if (in_debug_taken) begin
      // Trigger is not rechecked here, old cause holds otherwise
      if (ebreak_to_debug) begin
        cause_q <= dbg_monitor_pkg::EBREAK;
      end else if (obs_i.debug_req) begin
        cause_q <= dbg_monitor_pkg::HALTREQ;
      end else if (obs_i.dcsr_step) begin
        cause_q <= dbg_monitor_pkg::STEP;
      end
    end
  end

  // --------------------------------------------------
  // WFI sleep state
  // --------------------------------------------------
  assign wfi_enter = events_i.is_wfi && !obs_i.debug_req && !obs_i.debug_mode &&
                     !obs_i.dcsr_step;
  assign wfi_wake  = obs_i.pending_irq || obs_i.debug_req;

  always_ff @(posedge cov_assert_if) begin
    if (reset_i) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_wake) begin
      in_wfi_q <= 1'b0;
    end else if (wfi_enter) begin
      in_wfi_q <= 1'b1;
    end
  end

  assign cause_o  = cause_q;
  assign in_wfi_o = in_wfi_q;

endmodule

//--- rtl/instr_classifier.sv
/* Combinational decode of the write-back and decode instruction words
   into monitor event flags */

`timescale 1ns/100ps
`include "dbg_monitor_settings.svh"

module instr_classifier (
  input  dbg_monitor_pkg::core_obs_t     obs_i,
  output dbg_monitor_pkg::instr_events_t events_o
);

  logic id_is_system;
  logic id_is_csr_op;
  logic csr_in_dbg_range;

  // --------------------------------------------------
  // Decode stage CSR access
  // --------------------------------------------------
  assign id_is_system = obs_i.id_valid && obs_i.id_decoding &&
                        (obs_i.id_instr.r.opcode == `DBG_OPCODE_SYSTEM);

  // funct3 of zero is a privileged op, dret lands in the CSR window otherwise
  assign id_is_csr_op = (obs_i.id_instr.i.funct3 != 3'b000);

  assign csr_in_dbg_range = (obs_i.id_instr.i.csr >= `DBG_CSR_DCSR_LO) &&
                            (obs_i.id_instr.i.csr <= `DBG_CSR_DCSR_HI);

  // --------------------------------------------------
  // Event flags
  // --------------------------------------------------
  always_comb begin
    // Write-back matches on the whole word
    events_o.is_ebreak  = obs_i.wb_valid && (obs_i.wb_instr == `DBG_INSTR_EBREAK);
    events_o.is_cebreak = obs_i.wb_valid && (obs_i.wb_instr == `DBG_INSTR_CEBREAK);
    events_o.is_wfi     = obs_i.wb_valid && (obs_i.wb_instr == `DBG_INSTR_WFI);
    events_o.is_dret    = obs_i.wb_valid && (obs_i.wb_instr == `DBG_INSTR_DRET);

    events_o.dbg_csr_access = id_is_system && id_is_csr_op && csr_in_dbg_range;
  end

endmodule

//--- rtl/dbg_monitor_pkg.sv
/* Types of the debug monitor: controller state, expected cause, instruction
   word views, observation bundle, status word and Wishbone request/response */

`include "dbg_monitor_settings.svh"

package dbg_monitor_pkg;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------
  typedef enum logic [1:0] {
    RESET       = 2'd0,
    BOOT_SET    = 2'd1,
    FUNCTIONAL  = 2'd2,
    DEBUG_TAKEN = 2'd3
  } ctrl_state_e;

  // Same values as dcsr.cause
  typedef enum logic [2:0] {
    NONE    = 3'd0,
    EBREAK  = 3'd1,
    TRIGGER = 3'd2,
    HALTREQ = 3'd3,
    STEP    = 3'd4
  } dbg_cause_e;

  // --------------------------------------------------
  // Instruction word
  // --------------------------------------------------
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [`DBG_CSR_FIELD_W-1:0] csr;
    logic [4:0]                  rs1;
    logic [2:0]                  funct3;
    logic [4:0]                  rd;
    logic [6:0]                  opcode;
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_word_u;

  // --------------------------------------------------
  // Observation bundle from the core
  // --------------------------------------------------
  typedef struct packed {
    ctrl_state_e          ctrl;
    logic                 debug_mode;
    logic                 dcsr_ebreakm;
    logic                 dcsr_step;
    logic                 debug_req;
    logic                 trigger_match;
    logic                 pending_irq;
    logic                 wb_valid;
    instr_word_u          wb_instr;
    logic [`DBG_XLEN-1:0] wb_pc;
    logic                 id_valid;
    logic                 id_decoding;
    instr_word_u          id_instr;
    logic [`DBG_XLEN-1:0] id_pc;
    logic                 rvfi_valid;
    logic [`DBG_XLEN-1:0] rvfi_pc;
    logic [`DBG_XLEN-1:0] dm_halt_addr;
    logic [`DBG_XLEN-1:0] dm_exception_addr;
    logic [`DBG_XLEN-1:0] boot_addr;
    logic                 illegal_insn;
    logic                 ecall_insn;
    logic                 pc_set;
  } core_obs_t;

  typedef struct packed {
    logic is_ebreak;
    logic is_cebreak;
    logic is_wfi;
    logic is_dret;
    logic dbg_csr_access;
  } instr_events_t;

  // Cause sits in bits 2:0, flags above it
  typedef struct packed {
    logic [24:0] pad;
    logic        sticky_mmode_dcsr;
    logic        sticky_mret_dret;
    logic        first_debug_ins;
    logic        in_wfi;
    dbg_cause_e  cause;
  } monitor_status_t;

  // --------------------------------------------------
  // Wishbone classic
  // --------------------------------------------------
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [`DBG_WB_ADDR_W-1:0] adr;
    logic [`DBG_XLEN-1:0]      dat_w;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic [`DBG_XLEN-1:0] dat_r;
  } wb_rsp_t;

endpackage

//--- rtl/dbg_monitor_settings.svh
/* Widths, instruction encodings, debug CSR range and the Wishbone register map
   of the debug-mode event monitor */

`ifndef DBG_MONITOR_SETTINGS_SVH
`define DBG_MONITOR_SETTINGS_SVH

// Data and address width of the core
`define DBG_XLEN 32

// Full instruction encodings seen in write-back
`define DBG_INSTR_EBREAK  32'h0010_0073
`define DBG_INSTR_CEBREAK 32'h0000_9002
`define DBG_INSTR_WFI     32'h1050_0073
`define DBG_INSTR_DRET    32'h7B20_0073

// SYSTEM opcode and debug CSR window (dcsr, dpc, dscratch0/1)
`define DBG_OPCODE_SYSTEM 7'h73
`define DBG_CSR_FIELD_W   12
`define DBG_CSR_DCSR_LO   12'h7B0
`define DBG_CSR_DCSR_HI   12'h7B3

// Wishbone word indices
`define DBG_WB_ADDR_W     3
`define DBG_REG_STATUS    3'd0
`define DBG_REG_PC_DEBUG  3'd1
`define DBG_REG_PC_EBREAK 3'd2
`define DBG_REG_HALT      3'd3
`define DBG_REG_EXC       3'd4
`define DBG_REG_BOOT      3'd5

`endif
